// File: design/accel_pkg.sv
package accel_pkg;

  localparam int IO_DATA_WIDTH = 32;
  localparam int IO_ADDR_WIDTH = 5;
  localparam int LEN_WIDTH     = 12;
  localparam int PTR_WIDTH     = 16;
  localparam int RULE_ID_WIDTH = 16;

  // Word index on io_addr[4:2]
  typedef enum logic [2:0] {
    REG_CTRL   = 3'd0,
    REG_LEN    = 3'd1,
    REG_ADDR   = 3'd2,
    REG_RESULT = 3'd3,
    REG_LEVEL  = 3'd4
  } reg_idx_t;

  typedef struct packed {
    logic [PTR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0] len;
  } desc_t;

  // Valid bytes run from 1 to 4 starting at the low byte
  typedef struct packed {
    logic [31:0] data;
    logic [2:0]  bytes;
    logic        last;
  } beat_t;

  typedef struct packed {
    logic [31:0]              pattern;
    logic [RULE_ID_WIDTH-1:0] id;
  } rule_t;

  typedef struct packed {
    logic                     hit;
    logic [RULE_ID_WIDTH-1:0] rule_id;
    logic [7:0]               count;
  } result_t;

endpackage

// File: design/accel_wrap.sv
`timescale 1ns/1ns

module accel_wrap import accel_pkg::*; #(
  parameter int MEM_ADDR_WIDTH = 10,
  parameter int RULE_COUNT     = 8
) (
  input  logic                          clk,
  input  logic                          rst,

  input  logic                          io_en,
  input  logic                          io_wen,
  input  logic [IO_DATA_WIDTH/8-1:0]    io_strb,
  input  logic [IO_ADDR_WIDTH-1:0]      io_addr,
  input  logic [IO_DATA_WIDTH-1:0]      io_wr_data,
  output logic [IO_DATA_WIDTH-1:0]      io_rd_data,
  output logic                          io_rd_valid,

  input  logic                          rule_wr_en,
  input  logic [$clog2(RULE_COUNT)-1:0] rule_wr_idx,
  input  rule_t                         rule_wr_data,

  output logic                          mem_rd_en,
  output logic [MEM_ADDR_WIDTH-1:0]     mem_rd_addr,
  input  logic [31:0]                   mem_rd_data
);

  localparam int QUEUE_DEPTH_LOG2 = 2;

  desc_t                     cmd_desc;
  logic                      cmd_valid;
  logic                      cmd_ready;
  desc_t                     dma_desc;
  logic                      dma_desc_valid;
  logic                      dma_desc_ready;
  logic                      stop;
  logic                      busy;
  logic                      last_done;
  beat_t                     beat;
  logic                      beat_valid;
  logic                      beat_ready;
  result_t                   scan_result;
  logic                      scan_result_valid;
  logic                      scan_result_ready;
  result_t                   host_result;
  logic                      host_result_valid;
  logic                      host_result_ready;
  logic [QUEUE_DEPTH_LOG2:0] result_level;

  mmio_regs #(
    .LEVEL_WIDTH(QUEUE_DEPTH_LOG2 + 1)
  ) regs_i (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .desc(cmd_desc), .desc_valid(cmd_valid), .desc_ready(cmd_ready),
    .stop(stop), .busy(busy), .last_done(last_done),
    .result(host_result), .result_valid(host_result_valid),
    .result_ready(host_result_ready), .result_level(result_level)
  );

  simple_fifo #(
    .DEPTH_LOG2(QUEUE_DEPTH_LOG2),
    .WIDTH($bits(desc_t))
  ) desc_fifo (
    .clk(clk), .rst(rst),
    .din(cmd_desc), .din_valid(cmd_valid), .din_ready(cmd_ready),
    .dout(dma_desc), .dout_valid(dma_desc_valid), .dout_ready(dma_desc_ready),
    .level()
  );

  pkt_rd_dma #(
    .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
  ) dma_i (
    .clk(clk), .rst(rst),
    .desc(dma_desc), .desc_valid(dma_desc_valid), .desc_ready(dma_desc_ready),
    .stop(stop),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data),
    .beat(beat), .beat_valid(beat_valid), .beat_ready(beat_ready),
    .busy(busy), .last_done(last_done)
  );

  pattern_scan #(
    .RULE_COUNT(RULE_COUNT)
  ) scan_i (
    .clk(clk), .rst(rst),
    .rule_wr_en(rule_wr_en), .rule_wr_idx(rule_wr_idx), .rule_wr_data(rule_wr_data),
    .beat(beat), .beat_valid(beat_valid), .beat_ready(beat_ready),
    .stop(stop),
    .result(scan_result), .result_valid(scan_result_valid),
    .result_ready(scan_result_ready)
  );

  simple_fifo #(
    .DEPTH_LOG2(QUEUE_DEPTH_LOG2),
    .WIDTH($bits(result_t))
  ) result_fifo (
    .clk(clk), .rst(rst),
    .din(scan_result), .din_valid(scan_result_valid), .din_ready(scan_result_ready),
    .dout(host_result), .dout_valid(host_result_valid), .dout_ready(host_result_ready),
    .level(result_level)
  );

endmodule

// File: design/mmio_regs.sv
`timescale 1ns/1ns

module mmio_regs import accel_pkg::*; #(
  parameter int LEVEL_WIDTH = 3
) (
  input  logic                       clk,
  input  logic                       rst,

  input  logic                       io_en,
  input  logic                       io_wen,
  input  logic [IO_DATA_WIDTH/8-1:0] io_strb,
  input  logic [IO_ADDR_WIDTH-1:0]   io_addr,
  input  logic [IO_DATA_WIDTH-1:0]   io_wr_data,
  output logic [IO_DATA_WIDTH-1:0]   io_rd_data,
  output logic                       io_rd_valid,

  output desc_t                      desc,
  output logic                       desc_valid,
  input  logic                       desc_ready,

  output logic                       stop,
  input  logic                       busy,
  input  logic                       last_done,

  input  result_t                    result,
  input  logic                       result_valid,
  output logic                       result_ready,
  input  logic [LEVEL_WIDTH-1:0]     result_level
);

  logic [LEN_WIDTH-1:0]     len_reg;
  logic [PTR_WIDTH-1:0]     addr_reg;
  logic                     start_reg;
  logic                     stop_reg;
  logic                     done_reg;
  logic                     overflow_reg;
  logic                     busy_q;
  logic                     stall_reg;
  logic [IO_DATA_WIDTH-1:0] rd_data_reg;
  logic                     rd_valid_reg;
  logic [2:0]               reg_idx;
  logic                     wr_req;
  logic                     rd_req;
  logic                     pop_req;

  assign reg_idx = io_addr[4:2];
  assign wr_req  = io_en && io_wen;
  // New reads are ignored while a result pop is stalled
  assign rd_req  = io_en && !io_wen && !stall_reg;
  assign pop_req = (rd_req && reg_idx == REG_RESULT) || stall_reg;

  assign result_ready = pop_req && result_valid;

  assign desc.addr   = addr_reg;
  assign desc.len    = len_reg;
  assign desc_valid  = start_reg;
  assign stop        = stop_reg;
  assign io_rd_data  = rd_data_reg;
  assign io_rd_valid = rd_valid_reg;

  // Host writes and command strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      start_reg <= 1'b0;
      stop_reg  <= 1'b0;
    end else begin
      start_reg <= 1'b0;
      stop_reg  <= 1'b0;
      if (wr_req && reg_idx == REG_CTRL && io_strb[0]) begin
        start_reg <= io_wr_data[0];
        stop_reg  <= io_wr_data[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_req && reg_idx == REG_LEN) len_reg <= io_wr_data[LEN_WIDTH-1:0];
    if (wr_req && reg_idx == REG_ADDR) addr_reg <= io_wr_data[PTR_WIDTH-1:0];
  end

  // Sticky status; busy rising marks a descriptor taken by the DMA
  always_ff @(posedge clk) begin
    if (rst) begin
      done_reg     <= 1'b0;
      overflow_reg <= 1'b0;
      busy_q       <= 1'b0;
    end else begin
      busy_q <= busy;
      if (last_done || stop_reg) done_reg <= 1'b1;
      else if (busy && !busy_q) done_reg <= 1'b0;
      if (start_reg && !desc_ready) overflow_reg <= 1'b1;
    end
  end

  // Registered read mux with the stalling result pop
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid_reg <= 1'b0;
      stall_reg    <= 1'b0;
    end else begin
      rd_valid_reg <= 1'b0;
      if (pop_req) begin
        stall_reg <= !result_valid;
        rd_valid_reg <= result_valid;
      end else if (rd_req) begin
        rd_valid_reg <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_req) begin
      rd_data_reg <= {result.hit, 7'd0, result.count, result.rule_id};
    end else if (rd_req) begin
      rd_data_reg <= '0;
      case (reg_idx)
        REG_CTRL:  rd_data_reg <= {15'd0, overflow_reg, 7'd0, done_reg, 7'd0, busy};
        REG_LEN:   rd_data_reg <= {{(IO_DATA_WIDTH-LEN_WIDTH){1'b0}}, len_reg};
        REG_ADDR:  rd_data_reg <= {{(IO_DATA_WIDTH-PTR_WIDTH){1'b0}}, addr_reg};
        REG_LEVEL: rd_data_reg <= {{(IO_DATA_WIDTH-LEVEL_WIDTH){1'b0}}, result_level};
        default:   rd_data_reg <= '0;
      endcase
    end
  end

endmodule

// File: design/pattern_scan.sv
`timescale 1ns/1ns

module pattern_scan import accel_pkg::*; #(
  parameter int RULE_COUNT = 8
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          rule_wr_en,
  input  logic [$clog2(RULE_COUNT)-1:0] rule_wr_idx,
  input  rule_t                         rule_wr_data,
  input  beat_t                         beat,
  input  logic                          beat_valid,
  output logic                          beat_ready,
  input  logic                          stop,
  output result_t                       result,
  output logic                          result_valid,
  input  logic                          result_ready
);

  rule_t                    slots [RULE_COUNT];
  logic [RULE_COUNT-1:0]    slot_valid;
  logic [31:0]              mask;
  logic                     win_any;
  logic [RULE_ID_WIDTH-1:0] win_id;
  logic                     pkt_hit;
  logic [RULE_ID_WIDTH-1:0] pkt_id;
  logic [7:0]               pkt_count;
  logic [7:0]               count_next;
  logic                     res_pending;
  result_t                  res_q;
  logic                     accept;

  assign beat_ready   = (!res_pending || result_ready) && !stop;
  assign accept       = beat_valid && beat_ready;
  assign result       = res_q;
  assign result_valid = res_pending;

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{3'(b) < beat.bytes}};
    end
  end

  // Walk downwards so the lowest matching slot is the one kept
  always_comb begin
    win_any = 1'b0;
    win_id  = '0;
    for (int i = RULE_COUNT - 1; i >= 0; i--) begin
      if (slot_valid[i] && ((beat.data ^ slots[i].pattern) & mask) == '0) begin
        win_any = 1'b1;
        win_id  = slots[i].id;
      end
    end
  end

  assign count_next = (win_any && pkt_count != 8'hFF) ? pkt_count + 1'b1 : pkt_count;

  always_ff @(posedge clk) begin
    if (rule_wr_en) slots[rule_wr_idx] <= rule_wr_data;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      slot_valid  <= '0;
      pkt_hit     <= 1'b0;
      pkt_count   <= '0;
      res_pending <= 1'b0;
    end else begin
      if (rule_wr_en) slot_valid[rule_wr_idx] <= 1'b1;
      if (result_ready) res_pending <= 1'b0;
      if (stop) begin
        pkt_hit   <= 1'b0;
        pkt_count <= '0;
      end else if (accept && beat.last) begin
        pkt_hit     <= 1'b0;
        pkt_count   <= '0;
        res_pending <= 1'b1;
      end else if (accept) begin
        pkt_count <= count_next;
        if (win_any) pkt_hit <= 1'b1;
      end
    end
  end

  // First winning rule of the packet
  always_ff @(posedge clk) begin
    if (accept && win_any && !pkt_hit) pkt_id <= win_id;
    if (accept && beat.last) begin
      res_q.hit     <= pkt_hit || win_any;
      res_q.rule_id <= pkt_hit ? pkt_id : win_id;
      res_q.count   <= count_next;
    end
  end

endmodule

// File: design/pkt_rd_dma.sv
`timescale 1ns/1ns

module pkt_rd_dma import accel_pkg::*; #(
  parameter int MEM_ADDR_WIDTH = 10
) (
  input  logic                      clk,
  input  logic                      rst,
  input  desc_t                     desc,
  input  logic                      desc_valid,
  output logic                      desc_ready,
  input  logic                      stop,
  output logic                      mem_rd_en,
  output logic [MEM_ADDR_WIDTH-1:0] mem_rd_addr,
  input  logic [31:0]               mem_rd_data,
  output beat_t                     beat,
  output logic                      beat_valid,
  input  logic                      beat_ready,
  output logic                      busy,
  output logic                      last_done
);

  typedef enum logic [1:0] {IDLE, READ, WAIT, HOLD} state_t;

  state_t                    state;
  logic [MEM_ADDR_WIDTH-1:0] addr_q;
  logic [LEN_WIDTH-1:0]      rem_q;
  logic [2:0]                nbytes;
  beat_t                     beat_q;

  // Bytes carried by the current word
  assign nbytes = (rem_q > LEN_WIDTH'(4)) ? 3'd4 : rem_q[2:0];

  assign desc_ready  = (state == IDLE) && !stop;
  assign mem_rd_en   = (state == READ);
  assign mem_rd_addr = addr_q;
  assign beat        = beat_q;
  assign beat_valid  = (state == HOLD);
  assign busy        = (state != IDLE);
  assign last_done   = beat_valid && beat_ready && beat_q.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else if (stop) begin
      // Any read in flight is simply not captured
      state <= IDLE;
    end else begin
      case (state)
        IDLE: if (desc_valid && desc.len != '0) state <= READ;
        READ: state <= WAIT;
        WAIT: state <= HOLD;
        HOLD: if (beat_ready) state <= beat_q.last ? IDLE : READ;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && desc_valid) begin
      addr_q <= desc.addr[MEM_ADDR_WIDTH-1:0];
      rem_q  <= desc.len;
    end else if (state == WAIT) begin
      beat_q.data  <= mem_rd_data;
      beat_q.bytes <= nbytes;
      beat_q.last  <= (rem_q <= LEN_WIDTH'(4));
      addr_q       <= addr_q + 1'b1;
      rem_q        <= rem_q - LEN_WIDTH'(nbytes);
    end
  end

endmodule

// File: design/simple_fifo.sv
`timescale 1ns/1ns

module simple_fifo #(
  parameter int DEPTH_LOG2 = 2,
  parameter int WIDTH      = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [WIDTH-1:0]      din,
  input  logic                  din_valid,
  output logic                  din_ready,
  output logic [WIDTH-1:0]      dout,
  output logic                  dout_valid,
  input  logic                  dout_ready,
  output logic [DEPTH_LOG2:0]   level
);

  localparam int DEPTH = 2 ** DEPTH_LOG2;

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  push;
  logic                  pop;

  assign din_ready  = (count != (DEPTH_LOG2 + 1)'(DEPTH));
  assign dout_valid = (count != '0);
  assign dout       = mem[rd_ptr];
  assign level      = count;

  assign push = din_valid && din_ready;
  assign pop  = dout_valid && dout_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Pointers wrap naturally at the power-of-two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop) count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

endmodule

// File: files.f
design/accel_pkg.sv
design/simple_fifo.sv
design/mmio_regs.sv
design/pkt_rd_dma.sv
design/pattern_scan.sv
design/accel_wrap.sv
sim/accel_wrap_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns -f files.f --top-module accel_wrap_tb
./obj_dir/Vaccel_wrap_tb | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation reported errors"
  exit 1
fi
echo "Simulation finished without errors"

// File: sim/accel_wrap_tb.sv
`timescale 1ns/1ns

module accel_wrap_tb import accel_pkg::*; ();

  localparam int PKT_COUNT   = 50;
  localparam int CYCLE_LIMIT = 200 * PKT_COUNT + 2000;

  logic                     clk;
  logic                     rst;
  logic                     io_en;
  logic                     io_wen;
  logic [3:0]               io_strb;
  logic [IO_ADDR_WIDTH-1:0] io_addr;
  logic [31:0]              io_wr_data;
  logic [31:0]              io_rd_data;
  logic                     io_rd_valid;
  logic                     rule_wr_en;
  logic [2:0]               rule_wr_idx;
  rule_t                    rule_wr_data;
  logic                     mem_rd_en;
  logic [9:0]               mem_rd_addr;
  logic [31:0]              mem_rd_data;

  integer      seed;
  int          errors;
  int          checks;
  int          cycles;
  logic [31:0] pkt_mem [1024];
  logic [9:0]  next_addr;
  logic [31:0] rule_pat [8];
  logic [15:0] rule_id [8];
  logic [7:0]  rule_ok;
  logic [31:0] exp_q [$];

  accel_wrap #(
    .MEM_ADDR_WIDTH(10),
    .RULE_COUNT(8)
  ) dut_i (
    .clk(clk), .rst(rst),
    .io_en(io_en), .io_wen(io_wen), .io_strb(io_strb), .io_addr(io_addr),
    .io_wr_data(io_wr_data), .io_rd_data(io_rd_data), .io_rd_valid(io_rd_valid),
    .rule_wr_en(rule_wr_en), .rule_wr_idx(rule_wr_idx), .rule_wr_data(rule_wr_data),
    .mem_rd_en(mem_rd_en), .mem_rd_addr(mem_rd_addr), .mem_rd_data(mem_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Packet memory with one cycle of read latency
  initial begin
    logic       req;
    logic [9:0] req_addr;
    mem_rd_data = '0;
    forever begin
      @(negedge clk);
      req = mem_rd_en;
      req_addr = mem_rd_addr;
      @(posedge clk);
      #1;
      if (req) mem_rd_data = pkt_mem[req_addr];
    end
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual == expected) else begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic write_reg(input reg_idx_t idx, input logic [31:0] data);
    io_en = 1'b1;
    io_wen = 1'b1;
    io_strb = 4'hF;
    io_addr = {idx, 2'b00};
    io_wr_data = data;
    tick();
    io_en = 1'b0;
    io_wen = 1'b0;
  endtask

  // Plain register read with a one-cycle valid pulse
  task automatic read_reg(input reg_idx_t idx, output logic [31:0] data);
    io_en = 1'b1;
    io_wen = 1'b0;
    io_addr = {idx, 2'b00};
    tick();
    io_en = 1'b0;
    checks++;
    assert (io_rd_valid) else begin
      $display("Read of %s got no io_rd_valid one cycle after the request", idx.name());
      errors++;
    end
    data = io_rd_data;
    tick();
    checks++;
    assert (!io_rd_valid) else begin
      $display("Read of %s held io_rd_valid for more than one cycle", idx.name());
      errors++;
    end
  endtask

  // Result pop stalls until the queue has an entry
  task automatic pop_result(output logic [31:0] data, output int waited);
    io_en = 1'b1;
    io_wen = 1'b0;
    io_addr = {REG_RESULT, 2'b00};
    tick();
    io_en = 1'b0;
    waited = 1;
    while (!io_rd_valid) begin
      tick();
      waited++;
    end
    data = io_rd_data;
  endtask

  task automatic check_next_result(input string name);
    logic [31:0] data;
    int          waited;
    pop_result(data, waited);
    check_value(name, exp_q.pop_front(), data);
  endtask

  task automatic load_rule(input int s);
    rule_wr_en = 1'b1;
    rule_wr_idx = 3'(s);
    rule_wr_data.pattern = rule_pat[3'(s)];
    rule_wr_data.id = rule_id[3'(s)];
    tick();
    rule_wr_en = 1'b0;
  endtask

  // Masked compare per word where the lowest valid slot wins and the first winner is kept
  function automatic logic [31:0] model_result(input logic [9:0] addr, input int len);
    int          rem;
    int          nb;
    logic [31:0] mask;
    logic [9:0]  a;
    logic        hit;
    logic        found;
    logic [15:0] id;
    logic [15:0] word_id;
    logic [7:0]  cnt;
    hit = 1'b0;
    id = '0;
    cnt = '0;
    rem = len;
    a = addr;
    while (rem > 0) begin
      nb = (rem > 4) ? 4 : rem;
      mask = 32'hFFFF_FFFF >> (8 * (4 - nb));
      found = 1'b0;
      word_id = '0;
      for (int s = 0; s < 8; s++) begin
        if (!found && rule_ok[3'(s)] && ((pkt_mem[a] ^ rule_pat[3'(s)]) & mask) == '0) begin
          found = 1'b1;
          word_id = rule_id[3'(s)];
        end
      end
      if (found) begin
        if (!hit) id = word_id;
        hit = 1'b1;
        if (cnt != 8'hFF) cnt++;
      end
      rem -= nb;
      a++;
    end
    return {hit, 7'd0, cnt, id};
  endfunction

  // About a third of the random words are copied from a rule slot
  task automatic fill_packet(input logic [9:0] addr, input int len);
    logic [9:0] a;
    int         slot;
    a = addr;
    for (int w = 0; w < (len + 3) / 4; w++) begin
      pkt_mem[a] = next_rand();
      if (next_rand() % 3 == 0) begin
        slot = int'(next_rand() % 8);
        pkt_mem[a] = rule_pat[3'(slot)];
      end
      a++;
    end
  endtask

  task automatic start_packet(input int len, input logic keep);
    logic [9:0] base;
    base = next_addr;
    fill_packet(base, len);
    write_reg(REG_LEN, 32'(len));
    write_reg(REG_ADDR, {22'd0, base});
    write_reg(REG_CTRL, 32'h1);
    if (keep) exp_q.push_back(model_result(base, len));
    next_addr = base + 10'((len + 3) / 4);
  endtask

  initial begin
    logic [31:0] data;
    logic [31:0] tmp;
    int          waited;
    seed = 32'ha753b163;
    errors = 0;
    checks = 0;
    next_addr = '0;
    rst = 1'b1;
    io_en = 1'b0;
    io_wen = 1'b0;
    io_strb = '0;
    io_addr = '0;
    io_wr_data = '0;
    rule_wr_en = 1'b0;
    rule_wr_idx = '0;
    rule_wr_data = '0;
    for (int i = 0; i < 1024; i++) pkt_mem[10'(i)] = 32'(i) * 32'h9E37_79B1;
    repeat (5) @(posedge clk);
    #1 rst = 1'b0;

    read_reg(REG_CTRL, data);
    check_value("reset_ctrl", 32'd0, data);
    read_reg(REG_LEVEL, data);
    check_value("reset_level", 32'd0, data);

    repeat (8) begin
      tmp = next_rand();
      write_reg(REG_LEN, {20'd0, tmp[11:0]});
      write_reg(REG_ADDR, {16'd0, tmp[31:16]});
      read_reg(REG_LEN, data);
      check_value("len_readback", {20'd0, tmp[11:0]}, data);
      read_reg(REG_ADDR, data);
      check_value("addr_readback", {16'd0, tmp[31:16]}, data);
    end

    // Slot 4 shadows slot 1 and slot 7 stays empty
    for (int s = 0; s < 8; s++) begin
      rule_pat[3'(s)] = next_rand();
      tmp = next_rand();
      rule_id[3'(s)] = tmp[15:0];
    end
    rule_pat[4] = rule_pat[1];
    rule_ok = 8'h7F;
    for (int s = 0; s < 7; s++) load_rule(s);

    repeat (40) begin
      start_packet(1 + int'(next_rand() % 64), 1'b1);
      check_next_result("scan_result");
    end

    start_packet(64, 1'b1);
    pop_result(data, waited);
    check_value("stall_result", exp_q.pop_front(), data);
    checks++;
    assert (waited >= 32) else begin
      $display("Result read returned after %0d cycles, before the packet could finish", waited);
      errors++;
    end

    // Six back-to-back starts overflow the descriptor queue
    for (int k = 0; k < 6; k++) start_packet(64, k < 5);
    repeat (2) tick();
    read_reg(REG_CTRL, data);
    check_value("desc_overflow", 32'd1, {31'd0, data[16]});
    data = '0;
    while (data != 32'd4) read_reg(REG_LEVEL, data);
    repeat (200) tick();
    read_reg(REG_LEVEL, data);
    check_value("level_full", 32'd4, data);
    repeat (5) check_next_result("queued_result");
    read_reg(REG_LEVEL, data);
    check_value("level_drained", 32'd0, data);

    // Stop with nothing queued behind
    start_packet(400, 1'b0);
    repeat (20) tick();
    read_reg(REG_CTRL, data);
    check_value("busy_status", 32'h001, data & 32'h101);
    write_reg(REG_CTRL, 32'h2);
    repeat (3) tick();
    read_reg(REG_CTRL, data);
    check_value("stop_status", 32'h100, data & 32'h101);
    // Long enough for the full packet to have ended without the stop
    repeat (400) tick();
    read_reg(REG_LEVEL, data);
    check_value("stop_level", 32'd0, data);

    // Stop with a short packet waiting in the queue
    start_packet(400, 1'b0);
    start_packet(1 + int'(next_rand() % 64), 1'b1);
    repeat (20) tick();
    write_reg(REG_CTRL, 32'h2);
    check_next_result("after_stop");
    read_reg(REG_LEVEL, data);
    check_value("after_stop_level", 32'd0, data);

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
